/* Makefile */
# Verilator build and run of the load/store queue testbench

TOP := lsq_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, pass only if the pass message is printed"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f list.f -o sim_$(TOP)
	@out="$$(./obj_dir/sim_$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "PASS: all tests"

clean:
	rm -rf obj_dir

/* bench/lsq_chk.sv */
// port-level protocol checks for the load/store queue, bound into lsq_top by the bind below
module lsq_chk (
  input logic clk,
  input logic rst,
  input logic i_ld,
  input logic i_st,
  input logic i_retire,
  input logic i_full,
  input logic i_empty
);

  // one operation per cycle from the core
  a_ld_st_excl: assert property (@(posedge clk) disable iff (rst) !(i_ld && i_st))
    else $error("load and store strobes high in the same cycle");

  // core must hold off while the queue is full
  a_no_issue_full: assert property (@(posedge clk) disable iff (rst) !((i_ld || i_st) && i_full))
    else $error("operation offered while the queue is full");

  // nothing to retire from an empty queue
  a_no_retire_empty: assert property (@(posedge clk) disable iff (rst) !(i_retire && i_empty))
    else $error("retire strobe while the queue is empty");

  // occupancy flags are exclusive
  a_full_empty: assert property (@(posedge clk) disable iff (rst) !(i_full && i_empty))
    else $error("full and empty high together");

endmodule

bind lsq_top lsq_chk u_chk (
  .clk      (clk),
  .rst      (rst),
  .i_ld     (i_ld),
  .i_st     (i_st),
  .i_retire (o_retire),
  .i_full   (o_full),
  .i_empty  (o_empty)
);

/* bench/lsq_tb.sv */
// directed testbench for lsq_top, a reference model predicts every retire; run through list.f
`include "lsq_config.svh"

module lsq_tb;
  import mem_pkg::*;
  import lsq_pkg::*;

  localparam int WAIT_LIMIT = 400; // cycles per wait loop

  logic     clk = 1'b0;
  logic     rst;
  logic     i_ld;
  logic     i_st;
  addr_t    i_addr;
  word_t    i_wdata;
  reg_tag_t i_tag;
  logic     o_retire;
  logic     o_is_store;
  word_t    o_rdata;
  reg_tag_t o_tag;
  logic     o_full;
  logic     o_empty;

  // reference model
  word_t    model_mem [`MEM_WORDS]; // word k starts at k
  logic     exp_st [$];             // expected retires, oldest first
  word_t    exp_data [$];
  reg_tag_t exp_tag [$];
  int       err_count = 0;

  always #4 clk = ~clk; // period 8

  lsq_top i_dut (
    .clk        (clk),
    .rst        (rst),
    .i_ld       (i_ld),
    .i_st       (i_st),
    .i_addr     (i_addr),
    .i_wdata    (i_wdata),
    .i_tag      (i_tag),
    .o_retire   (o_retire),
    .o_is_store (o_is_store),
    .o_rdata    (o_rdata),
    .o_tag      (o_tag),
    .o_full     (o_full),
    .o_empty    (o_empty)
  );

  task automatic stop_on_error();
    err_count++;
    $display("FAIL: see errors above");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_value(input string name, input word_t got, input word_t want);
    assert (got == want) else begin
      $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, want);
      stop_on_error();
    end
  endtask

  // head is stable between edges, sample the retire port at negedge
  always @(negedge clk) begin
    if (!rst && o_retire) begin
      if (exp_tag.size() == 0) begin
        $display("ERROR: an entry retired while the model had nothing outstanding");
        stop_on_error();
      end else begin
        check_value("o_is_store", 32'(o_is_store), 32'(exp_st[0]));
        check_value("o_rdata", o_rdata, exp_data[0]);
        check_value("o_tag", 32'(o_tag), 32'(exp_tag[0]));
        void'(exp_st.pop_front());
        void'(exp_data.pop_front());
        void'(exp_tag.pop_front());
      end
    end
  end

  task automatic idle_cycle();
    @(posedge clk);
    i_ld <= 1'b0;
    i_st <= 1'b0;
  endtask

  // one operation, accepted on the next edge; model updated in issue order
  task automatic drive_op(input logic is_st, input addr_t addr, input word_t wdata,
                          input reg_tag_t tag);
    int       waited;
    mem_idx_t widx;
    waited = 0;
    widx   = addr[`MEM_IDX_W+1:2];
    @(posedge clk);
    // outstanding count equals the occupancy seen at acceptance
    while (exp_tag.size() >= `LSQ_DEPTH) begin
      i_ld <= 1'b0;
      i_st <= 1'b0;
      @(posedge clk);
      waited++;
      if (waited > WAIT_LIMIT) begin
        $display("ERROR: timed out waiting for a free queue slot");
        stop_on_error();
      end
    end
    i_ld    <= ~is_st;
    i_st    <= is_st;
    i_addr  <= addr;
    i_wdata <= wdata;
    i_tag   <= tag;
    if (is_st) begin
      model_mem[widx] = wdata; // store visible to every younger load
      exp_data.push_back('0);  // stores retire with zero data
    end else begin
      exp_data.push_back(model_mem[widx]);
    end
    exp_st.push_back(is_st);
    exp_tag.push_back(tag);
  endtask

  // until every modelled operation has retired
  task automatic wait_drain();
    int cycles;
    cycles = 0;
    idle_cycle();
    while (exp_tag.size() != 0) begin
      idle_cycle();
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        $display("ERROR: timed out with %0d operations not retired", exp_tag.size());
        stop_on_error();
      end
    end
  endtask

  task automatic wait_empty();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!o_empty) begin
      @(negedge clk);
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        $display("ERROR: timed out waiting for the queue to report empty");
        stop_on_error();
      end
    end
  endtask

  task automatic test_reset_state();
    @(negedge clk);
    check_value("o_empty", 32'(o_empty), 32'd1);
    check_value("o_full", 32'(o_full), 32'd0);
    check_value("o_retire", 32'(o_retire), 32'd0);
  endtask

  task automatic test_mem_read();
    drive_op(1'b0, 32'd148, '0, 4'h3); // word 37
    drive_op(1'b0, 32'hffc, '0, 4'h5); // last word
    drive_op(1'b0, 32'h000, '0, 4'h9);
    wait_drain();
  endtask

  task automatic test_mem_write();
    drive_op(1'b1, 32'h040, 32'hdead_beef, 4'h1);
    wait_drain(); // store gone from the queue, load must read memory
    drive_op(1'b0, 32'h040, '0, 4'h2);
    wait_drain();
  endtask

  task automatic test_forward();
    drive_op(1'b1, 32'h080, 32'h1234_5678, 4'h4);
    drive_op(1'b0, 32'h080, '0, 4'h5);
    drive_op(1'b1, 32'h084, 32'haaaa_0001, 4'h6);
    drive_op(1'b1, 32'h084, 32'hbbbb_0002, 4'h7); // younger store wins
    drive_op(1'b0, 32'h084, '0, 4'h8);
    wait_drain();
  endtask

  task automatic test_in_order();
    for (int i = 0; i < 12; i++) begin
      drive_op(i % 3 == 0, 32'h300 + 32'(4 * (i % 4)), 32'hc0de_0000 | 32'(i),
               reg_tag_t'(15 - i)); // tags 15 down to 4
    end
    wait_drain();
    // last retire edge just passed, occupancy back to zero
    @(negedge clk);
    check_value("o_empty", 32'(o_empty), 32'd1);
  endtask

  task automatic test_random();
    logic  is_st;
    addr_t addr;
    for (int i = 0; i < 200; i++) begin
      is_st = ($urandom_range(1, 0) == 1);
      addr  = 32'h500 + 4 * $urandom_range(7, 0); // 8 words
      drive_op(is_st, addr, $urandom, reg_tag_t'(i));
      if ($urandom_range(3, 0) == 0) begin
        idle_cycle();
      end
    end
    wait_drain();
    wait_empty();
  endtask

  initial begin
    void'($urandom(83165));
    rst     <= 1'b1;
    i_ld    <= 1'b0;
    i_st    <= 1'b0;
    i_addr  <= '0;
    i_wdata <= '0;
    i_tag   <= '0;
    for (int k = 0; k < `MEM_WORDS; k++) begin
      model_mem[k] = word_t'(k);
    end
    repeat (4) @(posedge clk);
    rst <= 1'b0;

    test_reset_state();
    test_mem_read();
    test_mem_write();
    test_forward();
    test_in_order();
    test_random();

    if (err_count == 0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      $display("FAIL: see errors above");
      $fatal(1, "errors were reported");
    end
  end

endmodule

/* list.f */
+incdir+logic
logic/mem_pkg.sv
logic/lsq_pkg.sv
logic/mem_if.sv
logic/ldst_queue.sv
logic/store_forward.sv
logic/data_mem.sv
logic/lsq_top.sv
bench/lsq_chk.sv
bench/lsq_tb.sv

/* logic/data_mem.sv */
// fixed two-cycle word memory model behind the queue, word k holds k after reset
`include "lsq_config.svh"

module data_mem (
  input  logic clk,
  input  logic rst,
  mem_if.mem   mif
);
  import mem_pkg::*;
  import lsq_pkg::*;

  word_t    mem [`MEM_WORDS]; // word array
  mem_idx_t idx;              // word index of the request

  // two response stages give the fixed latency
  logic     s1_valid;
  slot_id_t s1_id;
  word_t    s1_data;
  logic     s2_valid;
  slot_id_t s2_id;
  word_t    s2_data;

  assign idx = mif.req_addr[`MEM_IDX_W+1:2]; // byte address to word

  // contents and stage valids
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int k = 0; k < `MEM_WORDS; k++) begin
        mem[k] <= word_t'(k); // known pattern
      end
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else begin
      if (mif.req_valid && mif.req_rw) begin
        mem[idx] <= mif.req_wdata; // write at the request edge
      end
      s1_valid <= mif.req_valid; // every request is taken
      s2_valid <= s1_valid;
    end
  end

  // read data and ids ride along, qualified by the valids
  always_ff @(posedge clk) begin
    s1_id   <= mif.req_id;
    s1_data <= mif.req_rw ? '0 : mem[idx]; // old value, writes return zero
    s2_id   <= s1_id;
    s2_data <= s1_data;
  end

  // response, in request order
  assign mif.rsp_valid = s2_valid;
  assign mif.rsp_id    = s2_id;
  assign mif.rsp_data  = s2_data;

endmodule

/* logic/ldst_queue.sv */
// in-order load/store queue: allocates slots, issues memory requests, collects responses, retires
`include "lsq_config.svh"

module ldst_queue (
  input  logic                clk,
  input  logic                rst,
  // core side
  input  logic                i_ld,
  input  logic                i_st,
  input  mem_pkg::addr_t      i_addr,
  input  mem_pkg::word_t      i_wdata,
  input  lsq_pkg::reg_tag_t   i_tag,
  // forward search result for the operation at the inputs
  input  logic                i_fwd_hit,
  input  mem_pkg::word_t      i_fwd_data,
  // queue state fed to the forward search
  output lsq_pkg::lsq_entry_t o_entries [`LSQ_DEPTH],
  output lsq_pkg::slot_id_t   o_head,
  output lsq_pkg::slot_id_t   o_tail,
  // memory side
  mem_if.queue                mif,
  // retire and status
  output logic                o_retire,
  output mem_pkg::word_t      o_rdata,
  output lsq_pkg::reg_tag_t   o_tag,
  output logic                o_is_store,
  output logic                o_full,
  output logic                o_empty
);
  import mem_pkg::*;
  import lsq_pkg::*;

  lsq_entry_t entries [`LSQ_DEPTH]; // circular buffer
  slot_id_t   head;                 // oldest entry
  slot_id_t   tail;                 // next free slot
  count_t     count;                // occupied slots

  logic       accept; // operation taken this edge
  logic       fwd_ld; // load satisfied from an older store
  logic       retire; // head leaves this edge
  lsq_entry_t head_e;

  // offers while full are dropped, the core is told via o_full
  assign accept = (i_ld | i_st) & ~o_full;
  // only a load may use the forward hit
  assign fwd_ld = accept & i_ld & i_fwd_hit;

  assign head_e = entries[head];
  assign retire = head_e.valid & head_e.done; // strictly in order

  // slot state, pointers and request strobe
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int k = 0; k < `LSQ_DEPTH; k++) begin
        entries[k].valid <= 1'b0;
        entries[k].done  <= 1'b0;
      end
      head          <= '0;
      tail          <= '0;
      count         <= '0;
      mif.req_valid <= 1'b0;
    end else begin
      // pop head, never the same slot as tail or a pending response
      if (retire) begin
        entries[head].valid <= 1'b0;
        entries[head].done  <= 1'b0;
        head                <= head + 1'b1;
      end

      // allocate at tail
      if (accept) begin
        entries[tail].valid    <= 1'b1;
        entries[tail].is_store <= i_st;
        entries[tail].done     <= fwd_ld; // forwarded load completes at once
        entries[tail].addr     <= i_addr;
        entries[tail].data     <= fwd_ld ? i_fwd_data : i_wdata;
        entries[tail].tag      <= i_tag;
        tail                   <= tail + 1'b1;
      end

      // memory answer completes its slot
      if (mif.rsp_valid) begin
        entries[mif.rsp_id].done <= 1'b1;
        if (!entries[mif.rsp_id].is_store) begin
          entries[mif.rsp_id].data <= mif.rsp_data; // keep store data for forwarding
        end
      end

      count <= count + count_t'(accept) - count_t'(retire);

      // request is valid the cycle after acceptance
      mif.req_valid <= accept & ~fwd_ld;
    end
  end

  // request payload, only meaningful with req_valid
  always_ff @(posedge clk) begin
    if (accept) begin
      mif.req_rw    <= i_st;
      mif.req_addr  <= i_addr;
      mif.req_wdata <= i_wdata;
      mif.req_id    <= tail; // slot id comes back on rsp_id
    end
  end

  // search view
  assign o_entries = entries;
  assign o_head    = head;
  assign o_tail    = tail;

  // retire port, combinational from the head slot
  assign o_retire   = retire;
  assign o_is_store = head_e.is_store;
  assign o_rdata    = head_e.is_store ? '0 : head_e.data; // stores show zero
  assign o_tag      = head_e.tag;

  assign o_full  = (count == count_t'(`LSQ_DEPTH));
  assign o_empty = (count == '0);

endmodule

/* logic/lsq_config.svh */
// sizing macros for the load/store queue and data memory, include before any module that sizes ports
`ifndef LSQ_CONFIG_SVH
`define LSQ_CONFIG_SVH

// queue geometry
`define LSQ_DEPTH 16 // slots in the queue
`define LSQ_ID_W  4  // slot id, log2 of depth
`define LSQ_TAG_W 4  // writeback register tag

// datapath
`define DATA_W 32 // one memory word
`define ADDR_W 32 // byte address from the core

// data memory
`define MEM_WORDS 1024 // 4 KB of words
`define MEM_IDX_W 10   // word index, addr[11:2]

`endif

/* logic/lsq_pkg.sv */
// queue-side types: slot ids, register tags, occupancy and the queue entry layout
`include "lsq_config.svh"

package lsq_pkg;

  // queue slot, also the id carried on memory requests
  typedef logic [`LSQ_ID_W-1:0] slot_id_t;

  // writeback register tag, passed through untouched
  typedef logic [`LSQ_TAG_W-1:0] reg_tag_t;

  // occupancy, one bit wider than the slot id so full fits
  typedef logic [`LSQ_ID_W:0] count_t;

  // one queue slot, 71 bits
  typedef struct packed {
    logic           valid;    // slot occupied
    logic           is_store; // 1 store, 0 load
    logic           done;     // data present, may retire
    mem_pkg::addr_t addr;     // byte address
    mem_pkg::word_t data;     // store data, or load result once done
    reg_tag_t       tag;      // writeback register
  } lsq_entry_t;

endpackage

/* logic/lsq_top.sv */
// top level of the load/store queue with its memory model, plain ports toward the core
`include "lsq_config.svh"

module lsq_top (
  input  logic              clk,
  input  logic              rst,
  input  logic              i_ld,     // load strobe
  input  logic              i_st,     // store strobe
  input  mem_pkg::addr_t    i_addr,
  input  mem_pkg::word_t    i_wdata,
  input  lsq_pkg::reg_tag_t i_tag,
  output logic              o_retire, // one cycle per retiring entry
  output logic              o_is_store,
  output mem_pkg::word_t    o_rdata,
  output lsq_pkg::reg_tag_t o_tag,
  output logic              o_full,
  output logic              o_empty
);
  import mem_pkg::*;
  import lsq_pkg::*;

  lsq_entry_t entries [`LSQ_DEPTH]; // queue view for the search
  slot_id_t   head;
  slot_id_t   tail;
  logic       fwd_hit;
  word_t      fwd_data;

  mem_if u_mif ();

  ldst_queue u_queue (
    .clk        (clk),
    .rst        (rst),
    .i_ld       (i_ld),
    .i_st       (i_st),
    .i_addr     (i_addr),
    .i_wdata    (i_wdata),
    .i_tag      (i_tag),
    .i_fwd_hit  (fwd_hit),
    .i_fwd_data (fwd_data),
    .o_entries  (entries),
    .o_head     (head),
    .o_tail     (tail),
    .mif        (u_mif),
    .o_retire   (o_retire),
    .o_rdata    (o_rdata),
    .o_tag      (o_tag),
    .o_is_store (o_is_store),
    .o_full     (o_full),
    .o_empty    (o_empty)
  );

  // searched with the live input address
  store_forward u_fwd (
    .i_entries (entries),
    .i_head    (head),
    .i_tail    (tail),
    .i_addr    (i_addr),
    .o_hit     (fwd_hit),
    .o_data    (fwd_data)
  );

  data_mem u_mem (
    .clk (clk),
    .rst (rst),
    .mif (u_mif)
  );

endmodule

/* logic/mem_if.sv */
// request/response bundle between the queue and the data memory, no handshake
interface mem_if;
  import mem_pkg::*;
  import lsq_pkg::*;

  // request side, driven by the queue from registers
  logic     req_valid; // one request per cycle at most
  logic     req_rw;    // 1 write, 0 read
  addr_t    req_addr;
  word_t    req_wdata;
  slot_id_t req_id;    // queue slot that owns the request

  // response side, exactly two cycles after the request
  logic     rsp_valid;
  slot_id_t rsp_id;
  word_t    rsp_data;  // zero for writes

  modport queue (
    output req_valid, req_rw, req_addr, req_wdata, req_id,
    input  rsp_valid, rsp_id, rsp_data
  );

  // memory always accepts, answers in request order
  modport mem (
    input  req_valid, req_rw, req_addr, req_wdata, req_id,
    output rsp_valid, rsp_id, rsp_data
  );

endinterface

/* logic/mem_pkg.sv */
// memory-side types shared by the queue, the memory model and the request interface
`include "lsq_config.svh"

package mem_pkg;

  // one data word as seen by core and memory
  typedef logic [`DATA_W-1:0] word_t;

  // byte address, low two bits ignored by the memory
  typedef logic [`ADDR_W-1:0] addr_t;

  // word index into the memory array
  // taken from addr[11:2]
  typedef logic [`MEM_IDX_W-1:0] mem_idx_t;

endpackage

/* logic/store_forward.sv */
// combinational search for the youngest older store matching a new load address
`include "lsq_config.svh"

module store_forward (
  input  lsq_pkg::lsq_entry_t i_entries [`LSQ_DEPTH],
  input  lsq_pkg::slot_id_t   i_head,
  input  lsq_pkg::slot_id_t   i_tail,
  input  mem_pkg::addr_t      i_addr,
  output logic                o_hit,
  output mem_pkg::word_t      o_data
);
  import mem_pkg::*;
  import lsq_pkg::*;

  slot_id_t idx;      // slot under test, walks back from tail
  logic     in_range; // still between tail and head

  // youngest first, so the first match wins
  // i_ld is not looked at, the queue decides
  always_comb begin
    o_hit    = 1'b0;
    o_data   = '0;
    in_range = 1'b1;
    idx      = i_tail;
    for (int k = 0; k < `LSQ_DEPTH; k++) begin
      idx = idx - 1'b1; // wraps with the slot id width
      if (in_range && !o_hit &&
          i_entries[idx].valid &&
          i_entries[idx].is_store &&
          (i_entries[idx].addr == i_addr)) begin
        o_hit  = 1'b1;
        o_data = i_entries[idx].data;
      end
      // head is the oldest slot, stop after it
      if (idx == i_head) begin
        in_range = 1'b0;
      end
    end
  end

endmodule
